//--- run_sim.sh
#!/bin/sh
# build with Verilator, then look for the pass line in the output
verilator --binary --timing --assert --Wno-fatal -f sim.f --top-module tb_tmu -o tb_tmu \
	&& ./obj_dir/tb_tmu | tee /dev/stderr | grep -q "TEST PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sim.f
+incdir+.
tmu_regs_pkg.sv
tmu_pix_pkg.sv
tmu_ctlif.sv
tmu_scan.sv
tmu_clamp.sv
tmu_texfetch.sv
tmu_decay.sv
tmu_burst.sv
tmu_top.sv
tb_tmu.sv

//--- tb_tmu.sv
module tb_tmu
	import tmu_regs_pkg::*, tmu_pix_pkg::*;
();

	localparam int SEED = 32'h04a1_893c;
	localparam int FB_WORDS = 4096; // pixel model size, addresses wrap
	localparam int RUN_AREA = 8 * 4 * 3 + 10 * 6 + 16 * 8; // all renders together
	localparam int WATCHDOG_CYCLES = RUN_AREA * 20 + 2000;

	logic        sys_clk = 1'b0;
	logic        sys_rst;
	logic [7:0]  paddr_i;
	logic        psel_i, penable_i, pwrite_i;
	logic [31:0] pwdata_i;
	logic [31:0] prdata_o;
	logic        pready_o;
	logic        tex_stb_o, tex_ack_i;
	fb_addr_t    tex_addr_o;
	pixel_t      tex_data_i;
	logic        fb_stb_o, fb_ack_i;
	word_addr_t  fb_addr_o;
	sel_t        fb_sel_o;
	logic [63:0] fb_data_o;
	logic        irq_o;

	logic [15:0] fb_mem [FB_WORDS];
	logic [15:0] exp_mem [FB_WORDS];
	int          tex_wait, fb_wait;
	logic        tex_armed, fb_armed;
	int          errors, runs_started, checked_runs, irq_rises;
	int          tex_reads, exp_reads;
	string       cur_test;

	// render settings, also programmed into the DUT
	int hoff, voff, sqw, sqh, tsx, tsy, dudx, dvdy;
	int thres, tvres, dhres, dvres, bright, key, chroma, tbase, dbase;
	logic [17:0] hmask, vmask;

	tmu_top tmu_top_i (.*);

	always #5 sys_clk = ~sys_clk;

	// texture port, ack after 0..3 cycles
	always @(negedge sys_clk) begin
		if (sys_rst) begin
			tex_ack_i = 1'b0;
			tex_armed = 1'b0;
		end else if (tex_ack_i) begin
			tex_ack_i = 1'b0; // taken at the last edge
		end else if (tex_stb_o) begin
			if (!tex_armed) begin
				tex_wait = $urandom_range(3, 0);
				tex_armed = 1'b1;
			end
			if (tex_wait == 0) begin
				tex_ack_i = 1'b1;
				tex_data_i = tex_addr_o[15:0] ^ 16'h5a3c;
				tex_armed = 1'b0;
				tex_reads++;
			end else
				tex_wait--;
		end
	end

	// framebuffer port, bytes written by select
	always @(negedge sys_clk) begin
		int p;
		if (sys_rst) begin
			fb_ack_i = 1'b0;
			fb_armed = 1'b0;
		end else if (fb_ack_i) begin
			fb_ack_i = 1'b0;
		end else if (fb_stb_o) begin
			if (!fb_armed) begin
				fb_wait = $urandom_range(3, 0);
				fb_armed = 1'b1;
			end
			if (fb_wait == 0) begin
				for (int k = 0; k < 8; k++) begin
					p = (int'(fb_addr_o) * 4 + k / 2) % FB_WORDS;
					if (fb_sel_o[k])
						fb_mem[p][8 * (k % 2) +: 8] = fb_data_o[8 * k +: 8];
				end
				fb_ack_i = 1'b1;
				fb_armed = 1'b0;
			end else
				fb_wait--;
		end
	end

	always @(posedge irq_o)
		irq_rises++;

	function automatic int tex_coord(logic [17:0] c, logic [17:0] m, int res);
		logic signed [17:0] cm;
		int ip;
		cm = c & m;
		ip = int'(cm) >>> 6; // integer part
		if (ip < 0)
			return 0;
		if (ip >= res)
			return res - 1;
		return ip;
	endfunction

	// expected framebuffer after one run, returns the on-screen point count
	function automatic int render_expected();
		int dx, dy, tu, tv, r, g, b;
		int n;
		logic [17:0] tx, ty;
		logic [23:0] ta, da;
		logic [15:0] texel;
		n = 0;
		for (int j = 0; j < sqh; j++) begin
			for (int i = 0; i < sqw; i++) begin
				dx = hoff + i;
				dy = voff + j;
				if (dx < 0 || dy < 0 || dx >= dhres || dy >= dvres)
					continue;
				n++; // every on-screen point reads one texel
				tx = 18'(tsx + i * dudx);
				ty = 18'(tsy + j * dvdy);
				tu = tex_coord(tx, hmask, thres);
				tv = tex_coord(ty, vmask, tvres);
				ta = 24'(tbase + tv * thres + tu);
				texel = ta[15:0] ^ 16'h5a3c;
				if (chroma != 0 && texel == 16'(key))
					continue;
				r = (int'(texel[15:11]) * (bright + 1)) >> 6;
				g = (int'(texel[10:5]) * (bright + 1)) >> 6;
				b = (int'(texel[4:0]) * (bright + 1)) >> 6;
				da = 24'(dbase + dy * dhres + dx);
				exp_mem[da % FB_WORDS] = {5'(r), 6'(g), 5'(b)};
			end
		end
		return n;
	endfunction

	// compares the whole model once irq_o rises
	initial begin
		forever begin
			@(posedge irq_o);
			@(negedge sys_clk);
			for (int a = 0; a < FB_WORDS; a++) begin
				if (fb_mem[a] !== exp_mem[a]) begin
					$display("Error %s: pixel %0h expected %h actual %h",
						cur_test, a, exp_mem[a], fb_mem[a]);
					errors++;
					break;
				end
			end
			checked_runs++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("watchdog expired, the DUT stopped making progress");
		$display("TEST FAIL");
		$finish;
	end

	task automatic check_pready(input logic [7:0] a);
		if (pready_o !== 1'b1) begin
			$display("pready_o was low in the access phase at %h in %s", a, cur_test);
			errors++;
		end
	endtask

	task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
		@(negedge sys_clk);
		paddr_i = a;
		pwdata_i = d;
		pwrite_i = 1'b1;
		psel_i = 1'b1;
		@(negedge sys_clk);
		penable_i = 1'b1;
		#1 check_pready(a);
		@(negedge sys_clk);
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] a, output logic [31:0] d);
		@(negedge sys_clk);
		paddr_i = a;
		pwrite_i = 1'b0;
		psel_i = 1'b1;
		@(negedge sys_clk);
		penable_i = 1'b1;
		#1 d = prdata_o;
		check_pready(a);
		@(negedge sys_clk);
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic expect_reg(input logic [7:0] a, input logic [31:0] exp_val);
		logic [31:0] d;
		apb_read(a, d);
		if (d !== exp_val) begin
			$display("Error %s: reg %h expected %h actual %h", cur_test, a, exp_val, d);
			errors++;
		end
	endtask

	task automatic write_and_check(input logic [7:0] a, input logic [31:0] d,
		input logic [31:0] mask);
		apb_write(a, d);
		expect_reg(a, d & mask);
	endtask

	task automatic program_regs();
		apb_write(REG_DST_OFS, ((voff & 'hfff) << 16) | (hoff & 'hfff));
		apb_write(REG_SQUARE, (sqh << 16) | sqw);
		apb_write(REG_TEX_START, tsx & 'h3ffff);
		apb_write(REG_TEX_START_Y, tsy & 'h3ffff);
		apb_write(REG_TEX_STEP, dudx & 'h3ffff);
		apb_write(REG_TEX_STEP_Y, dvdy & 'h3ffff);
		apb_write(REG_TEX_RES, (tvres << 16) | thres);
		apb_write(REG_TEX_MASK, 32'(hmask));
		apb_write(REG_TEX_MASK_Y, 32'(vmask));
		apb_write(REG_DST_RES, (dvres << 16) | dhres);
		apb_write(REG_LOOK, (key << 16) | bright);
		apb_write(REG_TEX_BASE, tbase);
		apb_write(REG_DST_BASE, dbase);
	endtask

	task automatic start_run();
		exp_mem = fb_mem;
		exp_reads = render_expected();
		tex_reads = 0;
		program_regs();
		runs_started++;
		apb_write(REG_CTL, (chroma << CTL_CHROMA) | 1);
	endtask

	task automatic finish_run();
		wait (checked_runs == runs_started);
		if (irq_rises != runs_started) begin
			$display("Error %s: irq rises expected %0d actual %0d", cur_test,
				runs_started, irq_rises);
			errors++;
		end
		if (tex_reads != exp_reads) begin
			$display("Error %s: texture reads expected %0d actual %0d", cur_test,
				exp_reads, tex_reads);
			errors++;
		end
		apb_write(REG_STAT, 32'h1);
		if (irq_o) begin
			$display("irq_o stayed high after STAT clear in %s", cur_test);
			errors++;
		end
	endtask

	task automatic report(input int err_before);
		if (errors == err_before)
			$display("test %s: ok", cur_test);
		else
			$display("test %s: failed with %0d errors", cur_test, errors - err_before);
	endtask

	initial begin
		int e;
		sys_rst = 1'b1;
		paddr_i = '0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		pwdata_i = '0;
		tex_ack_i = 1'b0;
		tex_data_i = '0;
		fb_ack_i = 1'b0;
		errors = 0;
		runs_started = 0;
		checked_runs = 0;
		irq_rises = 0;
		tex_reads = 0;
		exp_reads = 0;
		void'($urandom(SEED));
		for (int a = 0; a < FB_WORDS; a++)
			fb_mem[a] = 16'hdead;
		repeat (10) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		cur_test = "readback";
		e = errors;
		expect_reg(REG_STAT, 32'h0);
		write_and_check(REG_CTL, 32'h2, 32'h2);
		write_and_check(REG_CTL, 32'h0, 32'h2);
		write_and_check(REG_DST_OFS, 32'h5a5a_a5a5, 32'h0fff_0fff);
		write_and_check(REG_SQUARE, 32'h1234_5678, 32'h07ff_07ff);
		write_and_check(REG_TEX_START, 32'hfedc_ba98, 32'h3ffff);
		write_and_check(REG_TEX_START_Y, 32'h0123_4567, 32'h3ffff);
		write_and_check(REG_TEX_STEP, 32'h89ab_cdef, 32'h3ffff);
		write_and_check(REG_TEX_STEP_Y, 32'h3c3c_3c3c, 32'h3ffff);
		write_and_check(REG_TEX_RES, 32'h0765_0321, 32'h07ff_07ff);
		write_and_check(REG_TEX_MASK, 32'h0002_aaaa, 32'h3ffff);
		write_and_check(REG_TEX_MASK_Y, 32'h0001_5555, 32'h3ffff);
		write_and_check(REG_DST_RES, 32'h0400_0280, 32'h07ff_07ff);
		write_and_check(REG_LOOK, 32'hbeef_00ff, 32'hffff_003f);
		write_and_check(REG_TEX_BASE, 32'hff12_3456, 32'h00ff_ffff);
		write_and_check(REG_DST_BASE, 32'h7765_4321, 32'h00ff_ffff);
		report(e);

		cur_test = "identity";
		e = errors;
		hoff = 3;
		voff = 2;
		sqw = 8;
		sqh = 4;
		tsx = 0;
		tsy = 0;
		dudx = 64; // unit step in 6-bit fraction
		dvdy = 64;
		thres = 32;
		tvres = 32;
		hmask = 18'h3ffff;
		vmask = 18'h3ffff;
		dhres = 64;
		dvres = 64;
		bright = 63;
		key = 0;
		chroma = 0;
		tbase = 'h40;
		dbase = 'h100;
		start_run();
		finish_run();
		report(e);

		cur_test = "brightness";
		e = errors;
		bright = 31;
		hoff = 1;
		voff = 10;
		start_run();
		finish_run();
		report(e);

		cur_test = "chroma";
		e = errors;
		bright = 63;
		voff = 20;
		chroma = 1;
		key = ((tbase + 1 * thres + 2) & 'hffff) ^ 'h5a3c; // texel at u 2, v 1
		start_run();
		finish_run();
		report(e);

		cur_test = "clamp_clip";
		e = errors;
		chroma = 0;
		hoff = -2;
		voff = -1;
		sqw = 10;
		sqh = 6;
		tsx = -3 * 64;
		tsy = -64;
		dudx = 40 * 64; // larger than the texture
		dvdy = 3 * 64 + 32;
		thres = 16;
		tvres = 16;
		vmask = 18'h007c0;
		dhres = 6;
		dvres = 4;
		dbase = 'h800;
		start_run();
		finish_run();
		report(e);

		cur_test = "completion";
		e = errors;
		hoff = 5;
		voff = 7;
		sqw = 16;
		sqh = 8;
		tsx = 32;
		tsy = 0;
		dudx = 96;
		dvdy = 64;
		thres = 32;
		tvres = 32;
		vmask = 18'h3ffff;
		dhres = 64;
		dvres = 64;
		dbase = 'hc00;
		start_run();
		expect_reg(REG_CTL, 32'h1);
		apb_write(REG_CTL, 32'h1); // ignored, a run is in progress
		finish_run();
		expect_reg(REG_CTL, 32'h0);
		report(e);

		$display("%0d runs checked, %0d errors", checked_runs, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- tmu_burst.sv
`include "tmu_consts.svh"

module tmu_burst
	import tmu_pix_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic        flush_i,
	input  logic        pipe_stb_i,
	input  pixel_t      pixel_i,
	input  fb_addr_t    dst_addr_i,
	input  logic        fb_ack_i,
	output logic        pipe_ack_o,
	output logic        busy_o,
	output logic        fb_stb_o,
	output word_addr_t  fb_addr_o,
	output sel_t        fb_sel_o,
	output logic [63:0] fb_data_o
);

	logic        acc_valid; // a word is being assembled
	word_addr_t  acc_addr;
	sel_t        acc_sel;
	logic [63:0] acc_data;
	logic        flush_pend; // flush seen while the output was busy
	logic [1:0]  lane;
	sel_t        lane_sel;
	logic        same_word;
	logic        out_free;
	logic        emit;
	logic        take;

	assign lane = dst_addr_i[1:0];
	assign lane_sel = 8'b11 << {lane, 1'b0};
	assign same_word = acc_addr == dst_addr_i[`TMU_FB_AW-1:2];
	assign out_free = !fb_stb_o || fb_ack_i;
	assign emit = acc_valid && out_free
		&& (&acc_sel || flush_i || flush_pend || (pipe_stb_i && !same_word));
	assign pipe_ack_o = !acc_valid || emit || (same_word && !(&acc_sel));
	assign take = pipe_stb_i && pipe_ack_o;
	assign busy_o = acc_valid || fb_stb_o || flush_pend;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			acc_valid <= 1'b0;
			fb_stb_o <= 1'b0;
			flush_pend <= 1'b0;
		end else begin
			if (take)
				acc_valid <= 1'b1;
			else if (emit)
				acc_valid <= 1'b0;
			if (emit)
				fb_stb_o <= 1'b1;
			else if (fb_ack_i)
				fb_stb_o <= 1'b0;
			flush_pend <= (flush_i || flush_pend) && acc_valid && !emit;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (emit) begin
			fb_addr_o <= acc_addr;
			fb_sel_o <= acc_sel;
			fb_data_o <= acc_data;
		end
		if (take) begin
			acc_addr <= dst_addr_i[`TMU_FB_AW-1:2];
			acc_data[16*lane +: 16] <= pixel_i;
			if (acc_valid && !emit)
				acc_sel <= acc_sel | lane_sel; // merge into current word
			else
				acc_sel <= lane_sel; // fresh word
		end
	end

	a_sel_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fb_stb_o |-> fb_sel_o != '0);

endmodule

//--- tmu_clamp.sv
`include "tmu_consts.svh"

module tmu_clamp
	import tmu_pix_pkg::*;
(
	input  logic   sys_clk,
	input  logic   sys_rst,
	input  logic   pipe_stb_i,
	input  scr_t   dx_i,
	input  scr_t   dy_i,
	input  coord_t tx_i,
	input  coord_t ty_i,
	input  coord_t tex_hmask_i,
	input  coord_t tex_vmask_i,
	input  res_t   tex_hres_i,
	input  res_t   tex_vres_i,
	input  res_t   dst_hres_i,
	input  res_t   dst_vres_i,
	input  logic   pipe_ack_i,
	output logic   pipe_ack_o,
	output logic   busy_o,
	output logic   pipe_stb_o,
	output scr_t   dx_o,
	output scr_t   dy_o,
	output res_t   tu_o,
	output res_t   tv_o
);

	logic on_screen;

	// mask, drop the fraction, then pin to 0..res-1
	function automatic res_t tex_clamp(coord_t c, coord_t m, res_t r);
		coord_t                                  cm;
		logic signed [`TMU_COORD_W-`TMU_FRAC-1:0] ip;
		cm = c & m;
		ip = cm[`TMU_COORD_W-1:`TMU_FRAC];
		if (ip < 0)
			return '0;
		else if (ip[`TMU_RES_W-1:0] >= r)
			return r - 1'b1;
		else
			return ip[`TMU_RES_W-1:0];
	endfunction

	assign on_screen = !dx_i[`TMU_SCR_W-1] && !dy_i[`TMU_SCR_W-1]
		&& dx_i[`TMU_RES_W-1:0] < dst_hres_i && dy_i[`TMU_RES_W-1:0] < dst_vres_i;
	assign pipe_ack_o = !pipe_stb_o || pipe_ack_i;
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (pipe_ack_o)
			pipe_stb_o <= pipe_stb_i && on_screen; // off-screen points vanish here
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o) begin
			dx_o <= dx_i;
			dy_o <= dy_i;
			tu_o <= tex_clamp(tx_i, tex_hmask_i, tex_hres_i);
			tv_o <= tex_clamp(ty_i, tex_vmask_i, tex_vres_i);
		end
	end

endmodule

//--- tmu_consts.svh
`ifndef TMU_CONSTS_SVH
`define TMU_CONSTS_SVH

// texture coordinates are signed fixed point, 1.11.6
`define TMU_FRAC    6
`define TMU_COORD_W 18

`define TMU_SCR_W   12 // signed screen position
`define TMU_RES_W   11 // sizes and resolutions

// 16-bit pixel address, texture and framebuffer alike
`define TMU_FB_AW   24

`endif

//--- tmu_ctlif.sv
`include "tmu_consts.svh"

module tmu_ctlif
	import tmu_regs_pkg::*, tmu_pix_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic [7:0]  paddr_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	input  logic        busy_i,
	input  logic        done_i,
	output logic        irq_o,
	output logic        start_o,
	output scr_t        dst_hoffset_o,
	output scr_t        dst_voffset_o,
	output res_t        squarew_o,
	output res_t        squareh_o,
	output coord_t      tsx_o,
	output coord_t      tsy_o,
	output coord_t      dudx_o,
	output coord_t      dvdy_o,
	output res_t        tex_hres_o,
	output res_t        tex_vres_o,
	output coord_t      tex_hmask_o,
	output coord_t      tex_vmask_o,
	output res_t        dst_hres_o,
	output res_t        dst_vres_o,
	output logic [5:0]  brightness_o,
	output logic        chroma_en_o,
	output pixel_t      chroma_key_o,
	output fb_addr_t    tex_base_o,
	output fb_addr_t    dst_base_o
);

	logic     wr_en;
	tmu_reg_e reg_sel;

	assign pready_o = 1'b1; // no wait states
	assign wr_en = psel_i && penable_i && pwrite_i; // end of access phase
	assign reg_sel = tmu_reg_e'(paddr_i);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			start_o <= 1'b0;
			irq_o <= 1'b0;
			chroma_en_o <= 1'b0;
		end else begin
			start_o <= wr_en && reg_sel == REG_CTL && pwdata_i[CTL_START] && !busy_i;
			if (done_i)
				irq_o <= 1'b1; // sticky until cleared
			else if (wr_en && reg_sel == REG_STAT && pwdata_i[STAT_IRQ])
				irq_o <= 1'b0;
			if (wr_en && reg_sel == REG_CTL)
				chroma_en_o <= pwdata_i[CTL_CHROMA];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			case (reg_sel)
				REG_DST_OFS: begin
					dst_hoffset_o <= pwdata_i[`TMU_SCR_W-1:0];
					dst_voffset_o <= pwdata_i[FIELD_HI +: `TMU_SCR_W];
				end
				REG_SQUARE: begin
					squarew_o <= pwdata_i[`TMU_RES_W-1:0];
					squareh_o <= pwdata_i[FIELD_HI +: `TMU_RES_W];
				end
				REG_TEX_START:   tsx_o <= pwdata_i[`TMU_COORD_W-1:0];
				REG_TEX_START_Y: tsy_o <= pwdata_i[`TMU_COORD_W-1:0];
				REG_TEX_STEP:    dudx_o <= pwdata_i[`TMU_COORD_W-1:0];
				REG_TEX_STEP_Y:  dvdy_o <= pwdata_i[`TMU_COORD_W-1:0];
				REG_TEX_RES: begin
					tex_hres_o <= pwdata_i[`TMU_RES_W-1:0];
					tex_vres_o <= pwdata_i[FIELD_HI +: `TMU_RES_W];
				end
				REG_TEX_MASK:    tex_hmask_o <= pwdata_i[`TMU_COORD_W-1:0];
				REG_TEX_MASK_Y:  tex_vmask_o <= pwdata_i[`TMU_COORD_W-1:0];
				REG_DST_RES: begin
					dst_hres_o <= pwdata_i[`TMU_RES_W-1:0];
					dst_vres_o <= pwdata_i[FIELD_HI +: `TMU_RES_W];
				end
				REG_LOOK: begin
					brightness_o <= pwdata_i[5:0];
					chroma_key_o <= pwdata_i[FIELD_HI +: 16];
				end
				REG_TEX_BASE:    tex_base_o <= pwdata_i[`TMU_FB_AW-1:0];
				REG_DST_BASE:    dst_base_o <= pwdata_i[`TMU_FB_AW-1:0];
				default: ;
			endcase
		end
	end

	// readback, valid during the access phase
	always_comb begin
		prdata_o = '0;
		case (reg_sel)
			REG_CTL: begin
				prdata_o[CTL_START] = busy_i;
				prdata_o[CTL_CHROMA] = chroma_en_o;
			end
			REG_STAT: prdata_o[STAT_IRQ] = irq_o;
			REG_DST_OFS: begin
				prdata_o[`TMU_SCR_W-1:0] = dst_hoffset_o;
				prdata_o[FIELD_HI +: `TMU_SCR_W] = dst_voffset_o;
			end
			REG_SQUARE: begin
				prdata_o[`TMU_RES_W-1:0] = squarew_o;
				prdata_o[FIELD_HI +: `TMU_RES_W] = squareh_o;
			end
			REG_TEX_START:   prdata_o[`TMU_COORD_W-1:0] = tsx_o;
			REG_TEX_START_Y: prdata_o[`TMU_COORD_W-1:0] = tsy_o;
			REG_TEX_STEP:    prdata_o[`TMU_COORD_W-1:0] = dudx_o;
			REG_TEX_STEP_Y:  prdata_o[`TMU_COORD_W-1:0] = dvdy_o;
			REG_TEX_RES: begin
				prdata_o[`TMU_RES_W-1:0] = tex_hres_o;
				prdata_o[FIELD_HI +: `TMU_RES_W] = tex_vres_o;
			end
			REG_TEX_MASK:    prdata_o[`TMU_COORD_W-1:0] = tex_hmask_o;
			REG_TEX_MASK_Y:  prdata_o[`TMU_COORD_W-1:0] = tex_vmask_o;
			REG_DST_RES: begin
				prdata_o[`TMU_RES_W-1:0] = dst_hres_o;
				prdata_o[FIELD_HI +: `TMU_RES_W] = dst_vres_o;
			end
			REG_LOOK: begin
				prdata_o[5:0] = brightness_o;
				prdata_o[FIELD_HI +: 16] = chroma_key_o;
			end
			REG_TEX_BASE:    prdata_o[`TMU_FB_AW-1:0] = tex_base_o;
			REG_DST_BASE:    prdata_o[`TMU_FB_AW-1:0] = dst_base_o;
			default: ;
		endcase
	end

	// top FSM must not restart a run in progress
	a_no_start_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
		start_o |-> !busy_i);

endmodule

//--- tmu_decay.sv
module tmu_decay
	import tmu_pix_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  logic       pipe_stb_i,
	input  pixel_t     pixel_i,
	input  fb_addr_t   dst_addr_i,
	input  logic [5:0] brightness_i,
	input  logic       chroma_en_i,
	input  pixel_t     chroma_key_i,
	input  logic       pipe_ack_i,
	output logic       pipe_ack_o,
	output logic       busy_o,
	output logic       pipe_stb_o,
	output pixel_t     pixel_o,
	output fb_addr_t   dst_addr_o
);

	logic [6:0]  gain; // brightness + 1, so 63 is unity
	logic [10:0] r_m;
	logic [11:0] g_m;
	logic [10:0] b_m;
	logic        keyed;

	assign gain = {1'b0, brightness_i} + 7'd1;
	assign r_m = pixel_i[15:11] * gain;
	assign g_m = pixel_i[10:5] * gain;
	assign b_m = pixel_i[4:0] * gain;
	assign keyed = chroma_en_i && pixel_i == chroma_key_i; // compared before scaling
	assign pipe_ack_o = !pipe_stb_o || pipe_ack_i;
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (pipe_ack_o)
			pipe_stb_o <= pipe_stb_i && !keyed;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o) begin
			pixel_o <= {r_m[10:6], g_m[11:6], b_m[10:6]}; // >>6 per channel
			dst_addr_o <= dst_addr_i;
		end
	end

endmodule

//--- tmu_pix_pkg.sv
`include "tmu_consts.svh"

package tmu_pix_pkg;

	typedef logic [15:0] pixel_t; // rgb565

	typedef logic signed [`TMU_COORD_W-1:0] coord_t;
	typedef logic signed [`TMU_SCR_W-1:0]   scr_t;
	typedef logic [`TMU_RES_W-1:0]          res_t;

	typedef logic [`TMU_FB_AW-1:0] fb_addr_t;
	typedef logic [`TMU_FB_AW-3:0] word_addr_t; // four pixels per 64-bit word
	typedef logic [7:0]            sel_t;

endpackage

//--- tmu_regs_pkg.sv
package tmu_regs_pkg;

	// word-aligned APB offsets
	typedef enum logic [7:0] {
		REG_CTL         = 8'h00,
		REG_STAT        = 8'h04,
		REG_DST_OFS     = 8'h08, // hoffset low, voffset high
		REG_SQUARE      = 8'h0C, // width low, height high
		REG_TEX_START   = 8'h10,
		REG_TEX_STEP    = 8'h14,
		REG_TEX_RES     = 8'h18, // hres low, vres high
		REG_TEX_MASK    = 8'h1C,
		REG_DST_RES     = 8'h20, // hres low, vres high
		REG_LOOK        = 8'h24, // brightness low, chroma key high
		REG_TEX_BASE    = 8'h28,
		REG_DST_BASE    = 8'h2C,
		REG_TEX_START_Y = 8'h30,
		REG_TEX_STEP_Y  = 8'h34,
		REG_TEX_MASK_Y  = 8'h38
	} tmu_reg_e;

	localparam int CTL_START  = 0; // write starts, read is busy
	localparam int CTL_CHROMA = 1;
	localparam int STAT_IRQ   = 0; // write 1 to clear
	localparam int FIELD_HI   = 16; // lsb of the upper field in paired registers

endpackage

//--- tmu_scan.sv
module tmu_scan
	import tmu_pix_pkg::*;
(
	input  logic   sys_clk,
	input  logic   sys_rst,
	input  logic   start_i,
	input  scr_t   dst_hoffset_i,
	input  scr_t   dst_voffset_i,
	input  res_t   squarew_i,
	input  res_t   squareh_i,
	input  coord_t tsx_i,
	input  coord_t tsy_i,
	input  coord_t dudx_i,
	input  coord_t dvdy_i,
	input  logic   pipe_ack_i,
	output logic   busy_o,
	output logic   pipe_stb_o,
	output scr_t   dx_o,
	output scr_t   dy_o,
	output coord_t tx_o,
	output coord_t ty_o
);

	res_t col;
	res_t row;
	logic last_col;
	logic step;

	assign last_col = (col == squarew_i - 1'b1);
	assign step = pipe_stb_o && pipe_ack_i;
	assign busy_o = pipe_stb_o; // drops once the last point is taken

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (start_i)
			pipe_stb_o <= 1'b1;
		else if (step && last_col && row == squareh_i - 1'b1)
			pipe_stb_o <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (start_i) begin
			col <= '0;
			row <= '0;
			dx_o <= dst_hoffset_i;
			dy_o <= dst_voffset_i;
			tx_o <= tsx_i;
			ty_o <= tsy_i;
		end else if (step) begin
			if (last_col) begin // wrap to next row
				col <= '0;
				row <= row + 1'b1;
				dx_o <= dst_hoffset_i;
				dy_o <= dy_o + 1'b1;
				tx_o <= tsx_i; // reload u at row start
				ty_o <= ty_o + dvdy_i;
			end else begin
				col <= col + 1'b1;
				dx_o <= dx_o + 1'b1;
				tx_o <= tx_o + dudx_i;
			end
		end
	end

endmodule

//--- tmu_texfetch.sv
module tmu_texfetch
	import tmu_pix_pkg::*;
(
	input  logic     sys_clk,
	input  logic     sys_rst,
	input  logic     pipe_stb_i,
	input  scr_t     dx_i,
	input  scr_t     dy_i,
	input  res_t     tu_i,
	input  res_t     tv_i,
	input  res_t     tex_hres_i,
	input  res_t     dst_hres_i,
	input  fb_addr_t tex_base_i,
	input  fb_addr_t dst_base_i,
	input  logic     tex_ack_i,
	input  pixel_t   tex_data_i,
	input  logic     pipe_ack_i,
	output logic     pipe_ack_o,
	output logic     busy_o,
	output logic     tex_stb_o,
	output fb_addr_t tex_addr_o,
	output logic     pipe_stb_o,
	output pixel_t   pixel_o,
	output fb_addr_t dst_addr_o
);

	fb_addr_t dst_addr_q; // rides along with the pending read
	logic     tex_done;

	assign tex_done = tex_stb_o && tex_ack_i;
	// one read in flight, and only when the output slot will be free
	assign pipe_ack_o = !tex_stb_o && (!pipe_stb_o || pipe_ack_i);
	assign busy_o = tex_stb_o || pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			tex_stb_o <= 1'b0;
			pipe_stb_o <= 1'b0;
		end else begin
			if (pipe_stb_i && pipe_ack_o)
				tex_stb_o <= 1'b1;
			else if (tex_done)
				tex_stb_o <= 1'b0;
			if (tex_done)
				pipe_stb_o <= 1'b1;
			else if (pipe_ack_i)
				pipe_stb_o <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o) begin
			tex_addr_o <= tex_base_i + tv_i * tex_hres_i + tu_i;
			dst_addr_q <= dst_base_i + dy_i * dst_hres_i + dx_i; // dx, dy known on-screen
		end
		if (tex_done) begin
			pixel_o <= tex_data_i;
			dst_addr_o <= dst_addr_q;
		end
	end

	a_tex_addr_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		tex_stb_o && !tex_ack_i |=> $stable(tex_addr_o));

endmodule

//--- tmu_top.sv
module tmu_top
	import tmu_pix_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic [7:0]  paddr_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        tex_stb_o,
	output fb_addr_t    tex_addr_o,
	input  logic        tex_ack_i,
	input  pixel_t      tex_data_i,
	output logic        fb_stb_o,
	output word_addr_t  fb_addr_o,
	output sel_t        fb_sel_o,
	output logic [63:0] fb_data_o,
	input  logic        fb_ack_i,
	output logic        irq_o
);

	typedef enum logic [1:0] {IDLE, WAIT_PROCESS, FLUSH, WAIT_FLUSH} state_e;

	state_e     state;
	state_e     next_state;
	logic       busy;
	logic       done;
	logic       flush;
	logic       start;
	scr_t       dst_hoffset, dst_voffset;
	res_t       squarew, squareh;
	coord_t     tsx, tsy, dudx, dvdy;
	res_t       tex_hres, tex_vres, dst_hres, dst_vres;
	coord_t     tex_hmask, tex_vmask;
	logic [5:0] brightness;
	logic       chroma_en;
	pixel_t     chroma_key;
	fb_addr_t   tex_base, dst_base;

	logic       scan_busy, scan_stb, scan_ack;
	scr_t       scan_dx, scan_dy;
	coord_t     scan_tx, scan_ty;
	logic       clamp_busy, clamp_stb, clamp_ack;
	scr_t       clamp_dx, clamp_dy;
	res_t       clamp_tu, clamp_tv;
	logic       fetch_busy, fetch_stb, fetch_ack;
	pixel_t     fetch_pixel;
	fb_addr_t   fetch_addr;
	logic       decay_busy, decay_stb, decay_ack;
	pixel_t     decay_pixel;
	fb_addr_t   decay_addr;
	logic       burst_busy;

	tmu_ctlif ctlif_i (
		.sys_clk, .sys_rst, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
		.prdata_o, .pready_o, .busy_i(busy), .done_i(done), .irq_o, .start_o(start),
		.dst_hoffset_o(dst_hoffset), .dst_voffset_o(dst_voffset),
		.squarew_o(squarew), .squareh_o(squareh),
		.tsx_o(tsx), .tsy_o(tsy), .dudx_o(dudx), .dvdy_o(dvdy),
		.tex_hres_o(tex_hres), .tex_vres_o(tex_vres),
		.tex_hmask_o(tex_hmask), .tex_vmask_o(tex_vmask),
		.dst_hres_o(dst_hres), .dst_vres_o(dst_vres),
		.brightness_o(brightness), .chroma_en_o(chroma_en), .chroma_key_o(chroma_key),
		.tex_base_o(tex_base), .dst_base_o(dst_base)
	);

	tmu_scan scan_i (
		.sys_clk, .sys_rst, .start_i(start),
		.dst_hoffset_i(dst_hoffset), .dst_voffset_i(dst_voffset),
		.squarew_i(squarew), .squareh_i(squareh),
		.tsx_i(tsx), .tsy_i(tsy), .dudx_i(dudx), .dvdy_i(dvdy),
		.pipe_ack_i(scan_ack), .busy_o(scan_busy), .pipe_stb_o(scan_stb),
		.dx_o(scan_dx), .dy_o(scan_dy), .tx_o(scan_tx), .ty_o(scan_ty)
	);

	tmu_clamp clamp_i (
		.sys_clk, .sys_rst, .pipe_stb_i(scan_stb),
		.dx_i(scan_dx), .dy_i(scan_dy), .tx_i(scan_tx), .ty_i(scan_ty),
		.tex_hmask_i(tex_hmask), .tex_vmask_i(tex_vmask),
		.tex_hres_i(tex_hres), .tex_vres_i(tex_vres),
		.dst_hres_i(dst_hres), .dst_vres_i(dst_vres),
		.pipe_ack_i(clamp_ack), .pipe_ack_o(scan_ack), .busy_o(clamp_busy),
		.pipe_stb_o(clamp_stb), .dx_o(clamp_dx), .dy_o(clamp_dy),
		.tu_o(clamp_tu), .tv_o(clamp_tv)
	);

	tmu_texfetch texfetch_i (
		.sys_clk, .sys_rst, .pipe_stb_i(clamp_stb),
		.dx_i(clamp_dx), .dy_i(clamp_dy), .tu_i(clamp_tu), .tv_i(clamp_tv),
		.tex_hres_i(tex_hres), .dst_hres_i(dst_hres),
		.tex_base_i(tex_base), .dst_base_i(dst_base),
		.tex_ack_i, .tex_data_i, .pipe_ack_i(fetch_ack), .pipe_ack_o(clamp_ack),
		.busy_o(fetch_busy), .tex_stb_o, .tex_addr_o,
		.pipe_stb_o(fetch_stb), .pixel_o(fetch_pixel), .dst_addr_o(fetch_addr)
	);

	tmu_decay decay_i (
		.sys_clk, .sys_rst, .pipe_stb_i(fetch_stb),
		.pixel_i(fetch_pixel), .dst_addr_i(fetch_addr),
		.brightness_i(brightness), .chroma_en_i(chroma_en), .chroma_key_i(chroma_key),
		.pipe_ack_i(decay_ack), .pipe_ack_o(fetch_ack), .busy_o(decay_busy),
		.pipe_stb_o(decay_stb), .pixel_o(decay_pixel), .dst_addr_o(decay_addr)
	);

	tmu_burst burst_i (
		.sys_clk, .sys_rst, .flush_i(flush), .pipe_stb_i(decay_stb),
		.pixel_i(decay_pixel), .dst_addr_i(decay_addr), .fb_ack_i,
		.pipe_ack_o(decay_ack), .busy_o(burst_busy),
		.fb_stb_o, .fb_addr_o, .fb_sel_o, .fb_data_o
	);

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		flush = 1'b0;
		done = 1'b0;
		case (state)
			IDLE: if (start) next_state = WAIT_PROCESS;
			WAIT_PROCESS: begin // drain everything ahead of the burst packer
				if (!(scan_busy || clamp_busy || fetch_busy || decay_busy))
					next_state = FLUSH;
			end
			FLUSH: begin
				flush = 1'b1; // push out the partial word
				next_state = WAIT_FLUSH;
			end
			WAIT_FLUSH: begin
				if (!burst_busy) begin
					done = 1'b1;
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	assign busy = state != IDLE;

endmodule
